//--- compile.f
common/bpu_pkg.sv
bpu_tables/btb_table.sv
bpu_tables/dir_predictor.sv
hdl/ras_stack.sv
hdl/bpu_update.sv
hdl/core_npc.sv
hdl/npc_top.sv
tb/clk_gen.sv
tb/npc_assertions.sv
tb/npc_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f compile.f --top-module npc_tb -o npc_sim
./obj_dir/npc_sim | tee sim.log

if grep -q "^NO ERRORS$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- tb/npc_tb.sv
`timescale 1ns/100ps

module npc_tb import bpu_pkg::*; ();

  localparam logic [31:0] RESET_PC   = 32'h1c00_0000;
  localparam int          DRIVE_DLY  = 10;
  localparam int          RST_CYCLES = 8;
  localparam logic [31:0] J0_PC      = 32'h1c00_1000;
  localparam logic [31:0] J1_PC      = 32'h1c00_1104;
  localparam logic [31:0] COND_PC    = 32'h1c00_3010;
  localparam logic [31:0] CALL_PC    = 32'h1c00_4008;
  localparam logic [31:0] RET_PC     = 32'h1c00_5020;

  typedef struct packed {
    logic [31:0]  pc;
    logic [31:0]  target;
    target_type_e ttype;
    logic         dir;
    logic [1:0]   cnt;
  } branch_t;

  typedef struct packed {
    logic [31:0]  pc0;
    logic [31:0]  pc1;
    logic [1:0]   valid;
    logic         taken;
    target_type_e ttype;
    logic         dir;
    logic [1:0]   cnt;
    logic [31:0]  push_pc;
    logic [31:0]  next_pc;
  } expect_t;

  logic             clk;
  logic             rst_n;
  logic             stall;
  logic             redirect;
  logic [31:0]      redirect_pc;
  bpu_correct_t     correct;
  logic [1:0][31:0] pc;
  logic [1:0]       valid;
  bpu_predict_t     predict;

  // reference state
  logic [31:0]          m_pc;
  branch_t              br_tab [8];
  int                   br_count;
  logic [31:0]          m_ras [RAS_DEPTH];
  logic [RAS_PTR_W-1:0] m_ras_ptr;
  expect_t              exp_q;
  logic                 spec_ok;
  int                   checks;
  int                   mismatches;
  int                   timeouts;

  clk_gen #(.PERIOD(100)) u_clk_gen (.clk_o(clk));

  npc_top #(.RESET_PC(RESET_PC)) dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .stall_i      (stall),
    .redirect_i   (redirect),
    .redirect_pc_i(redirect_pc),
    .correct_i    (correct),
    .pc_o         (pc),
    .valid_o      (valid),
    .predict_o    (predict)
  );

  bind core_npc npc_assertions u_npc_assertions (
    .clk          (clk),
    .rst_n        (rst_n),
    .stall_i      (stall_i),
    .redirect_i   (redirect_i),
    .redirect_pc_i(redirect_pc_i),
    .taken_i      (taken),
    .pc_i         (pc_o),
    .valid_i      (valid_o)
  );

  // two-bit saturating counter
  function automatic logic [1:0] sat_count(input logic [1:0] cnt, input logic taken);
    if (taken) begin
      return (cnt == 2'b11) ? cnt : cnt + 2'd1;
    end
    return (cnt == 2'b00) ? cnt : cnt - 2'd1;
  endfunction

  function automatic expect_t next_pair(input logic is_stall, input logic is_redir,
                                        input logic [31:0] redir_pc);
    expect_t              e;
    branch_t              b;
    int                   hit_idx;
    logic                 slot0;
    logic [RAS_PTR_W-1:0] top_idx;
    logic [31:0]          target;
    hit_idx = -1;
    for (int i = 0; i < br_count; i++) begin
      if (br_tab[i].pc[31:3] == m_pc[31:3] && (!m_pc[2] || br_tab[i].pc[2])) begin
        hit_idx = i;
      end
    end
    e = '0;
    e.pc0 = {m_pc[31:3], 3'b000};
    e.pc1 = e.pc0 + 32'd4;
    e.ttype = NPC;
    slot0 = 1'b0;
    target = '0;
    if (hit_idx >= 0) begin
      b = br_tab[hit_idx];
      top_idx = m_ras_ptr - 1'b1;
      e.ttype = b.ttype;
      e.dir = b.dir;
      e.cnt = b.cnt;
      e.taken = (b.ttype != NPC) && (!b.dir || b.cnt[1]);
      e.push_pc = b.pc + 32'd4;
      slot0 = !b.pc[2];
      target = (b.ttype == RETURN) ? m_ras[top_idx] : b.target;
    end
    if (is_stall) begin
      e.valid = 2'b00;
    end else if (e.taken && slot0) begin
      e.valid = 2'b01;
    end else if (m_pc[2]) begin
      e.valid = 2'b10;
    end else begin
      e.valid = 2'b11;
    end
    if (is_redir) begin
      e.next_pc = redir_pc;
    end else if (is_stall) begin
      e.next_pc = m_pc;
    end else if (e.taken) begin
      e.next_pc = target;
    end else begin
      e.next_pc = e.pc0 + 32'd8;
    end
    return e;
  endfunction

  task automatic learn_branch(input bpu_correct_t c);
    int idx;
    idx = br_count;
    for (int i = 0; i < br_count; i++) begin
      if (br_tab[i].pc[31:3] == c.pc[31:3]) begin
        idx = i;
      end
    end
    if (idx == br_count) begin
      br_count++;
    end
    br_tab[idx].pc     = c.pc;
    br_tab[idx].target = c.true_target;
    br_tab[idx].ttype  = c.true_target_type;
    br_tab[idx].dir    = c.true_dir;
    br_tab[idx].cnt    = c.true_dir ? sat_count(c.lphr, c.true_taken) : 2'b00;
  endtask

  // compare in the middle of the cycle, then step the model
  always @(negedge clk) begin
    if (!rst_n) begin
      m_pc      = RESET_PC;
      m_ras_ptr = '0;
      br_count  = 0;
    end else begin
      exp_q = next_pair(stall, redirect, redirect_pc);
      checks++;
      if (pc[0] !== exp_q.pc0) begin
        $display("mismatch at %0t: pc_o[0] is %h, expected %h", $time, pc[0], exp_q.pc0);
        mismatches++;
      end
      if (pc[1] !== exp_q.pc1) begin
        $display("mismatch at %0t: pc_o[1] is %h, expected %h", $time, pc[1], exp_q.pc1);
        mismatches++;
      end
      if (valid !== exp_q.valid) begin
        $display("mismatch at %0t: valid_o is %b, expected %b", $time, valid, exp_q.valid);
        mismatches++;
      end
      if (predict.taken !== exp_q.taken) begin
        $display("mismatch at %0t: taken is %b, expected %b", $time, predict.taken,
                 exp_q.taken);
        mismatches++;
      end
      // predicted pc is only the next pair when the register loads
      if ((!stall || redirect) && predict.predict_pc !== exp_q.next_pc) begin
        $display("mismatch at %0t: predict_pc is %h, expected %h", $time,
                 predict.predict_pc, exp_q.next_pc);
        mismatches++;
      end
      if (predict.target_type !== exp_q.ttype || predict.dir_type !== exp_q.dir) begin
        $display("mismatch at %0t: branch type is %0d/%b, expected %0d/%b", $time,
                 predict.target_type, predict.dir_type, exp_q.ttype, exp_q.dir);
        mismatches++;
      end
      if (exp_q.dir && predict.lphr !== exp_q.cnt) begin
        $display("mismatch at %0t: lphr is %b, expected %b", $time, predict.lphr,
                 exp_q.cnt);
        mismatches++;
      end
      if (predict.ras_ptr !== m_ras_ptr) begin
        $display("mismatch at %0t: ras_ptr is %0d, expected %0d", $time, predict.ras_ptr,
                 m_ras_ptr);
        mismatches++;
      end
      spec_ok = !stall && !redirect && exp_q.taken;
      if (spec_ok && exp_q.ttype == CALL) begin
        m_ras[m_ras_ptr] = exp_q.push_pc;
        m_ras_ptr = m_ras_ptr + 1'b1;
      end else if (spec_ok && exp_q.ttype == RETURN) begin
        m_ras_ptr = m_ras_ptr - 1'b1;
      end else if (correct.miss) begin
        if (correct.true_target_type == CALL) begin
          m_ras[correct.ras_ptr] = correct.pc + 32'd4;
          m_ras_ptr = correct.ras_ptr + 1'b1;
        end else begin
          m_ras_ptr = correct.ras_ptr;
        end
      end
      if (correct.miss) begin
        learn_branch(correct);
      end
      m_pc = exp_q.next_pc;
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic run_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic redirect_to(input logic [31:0] addr, input logic hold);
    stall       = hold;
    redirect    = 1'b1;
    redirect_pc = addr;
    next_cycle();
    redirect    = 1'b0;
  endtask

  task automatic send_correction(input logic [31:0] br_pc, input logic [31:0] target,
                                 input logic taken, input logic is_dir,
                                 input target_type_e ttype, input logic [1:0] lphr,
                                 input logic [HIST_W-1:0] hist);
    correct.miss             = 1'b1;
    correct.pc               = br_pc;
    correct.true_target      = target;
    correct.true_taken       = taken;
    correct.true_dir         = is_dir;
    correct.true_target_type = ttype;
    correct.lphr             = lphr;
    correct.history          = hist;
    correct.ras_ptr          = m_ras_ptr;
    next_cycle();
    correct = '0;
  endtask

  task automatic wait_for_pair(input logic [31:0] addr, input int max_cycles);
    int n;
    n = 0;
    while (pc[0] != addr && n < max_cycles) begin
      next_cycle();
      n++;
    end
    if (pc[0] != addr) begin
      $display("timeout at %0t waiting for fetch pair %h", $time, addr);
      timeouts++;
    end
  endtask

  initial begin
    void'($urandom(34));
    checks      = 0;
    mismatches  = 0;
    timeouts    = 0;
    rst_n       = 1'b0;
    stall       = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    correct     = '0;
    repeat (RST_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    run_cycles(4);
    for (int i = 0; i < 24; i++) begin
      stall = (($urandom % 3) == 0);
      next_cycle();
    end
    stall = 1'b0;
    run_cycles(2);
    // start in slot 1, then once more while stalled
    redirect_to(32'h1c00_0204, 1'b0);
    run_cycles(2);
    stall = 1'b1;
    next_cycle();
    redirect_to(32'h1c00_030c, 1'b1);
    stall = 1'b0;
    run_cycles(2);
    // train the tables while fetch is held
    stall = 1'b1;
    send_correction(J0_PC, 32'h1c00_2000, 1'b1, 1'b0, IMM, 2'b00, 4'b0000);
    send_correction(J1_PC, 32'h1c00_2100, 1'b1, 1'b0, IMM, 2'b00, 4'b0000);
    send_correction(COND_PC, 32'h1c00_3400, 1'b1, 1'b1, IMM, 2'b01, 4'b0000);
    send_correction(CALL_PC, 32'h1c00_5000, 1'b1, 1'b0, CALL, 2'b00, 4'b0000);
    send_correction(RET_PC, CALL_PC + 32'd4, 1'b1, 1'b0, RETURN, 2'b00, 4'b0000);
    redirect_to(J0_PC, 1'b0);
    run_cycles(2);
    redirect_to(J1_PC - 32'd4, 1'b0);
    run_cycles(2);
    redirect_to(J1_PC, 1'b0);
    run_cycles(2);
    redirect_to(COND_PC, 1'b0);
    run_cycles(1);
    // history after one taken is 0001, counter read was 10
    send_correction(COND_PC, 32'h1c00_3400, 1'b0, 1'b1, IMM, 2'b10, 4'b0001);
    run_cycles(1);
    redirect_to(COND_PC, 1'b0);
    run_cycles(2);
    redirect_to(CALL_PC, 1'b0);
    wait_for_pair(RET_PC, 8);
    wait_for_pair({CALL_PC[31:3], 3'b000}, 3);
    run_cycles(2);
    $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0 && checks > 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- tb/npc_assertions.sv
`timescale 1ns/100ps

module npc_assertions (
  input logic             clk,
  input logic             rst_n,
  input logic             stall_i,
  input logic             redirect_i,
  input logic [31:0]      redirect_pc_i,
  input logic             taken_i,
  input logic [1:0][31:0] pc_i,
  input logic [1:0]       valid_i
);

  // stalled pair is hidden and held
  property stall_holds_pair;
    @(posedge clk) disable iff (!rst_n)
      (stall_i && !redirect_i) |=> (pc_i == $past(pc_i)) && ($past(valid_i) == 2'b00);
  endproperty

  property redirect_lands;
    @(posedge clk) disable iff (!rst_n)
      redirect_i |=> (pc_i[0] == {$past(redirect_pc_i[31:3]), 3'b000});
  endproperty

  property seq_advance;
    @(posedge clk) disable iff (!rst_n)
      (!stall_i && !redirect_i && !taken_i) |=> (pc_i[0] == $past(pc_i[0]) + 32'd8);
  endproperty

  a_stall_hold: assert property (stall_holds_pair) else $error("pair moved or shown under stall");
  a_redirect:   assert property (redirect_lands) else $error("redirect pair not loaded");
  a_seq:        assert property (seq_advance) else $error("fall-through pair not plus 8");

endmodule

//--- tb/clk_gen.sv
`timescale 1ns/100ps

module clk_gen #(
  parameter int PERIOD = 100
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

//--- hdl/npc_top.sv
`timescale 1ns/100ps

module npc_top import bpu_pkg::*; #(
  parameter int          BTB_ADDR_W = 6,
  parameter int          BHT_ADDR_W = 4,
  parameter logic [31:0] RESET_PC   = 32'h1c00_0000
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             stall_i,
  input  logic             redirect_i,
  input  logic [31:0]      redirect_pc_i,
  input  bpu_correct_t     correct_i,
  output logic [1:0][31:0] pc_o,
  output logic [1:0]       valid_o,
  output bpu_predict_t     predict_o
);

  localparam int PHT_ADDR_W = HIST_W + 2;

  logic [BTB_ADDR_W-1:0] btb_raddr;
  btb_entry_t            btb_rdata;
  logic                  btb_we;
  logic [BTB_ADDR_W-1:0] btb_waddr;
  btb_entry_t            btb_wdata;

  logic [31:0]           dir_pc;
  logic [HIST_W-1:0]     history;
  logic [1:0]            lphr;
  logic                  bht_we;
  logic [BHT_ADDR_W-1:0] bht_waddr;
  logic [HIST_W-1:0]     bht_wdata;
  logic                  pht_we;
  logic [PHT_ADDR_W-1:0] pht_waddr;
  logic [1:0]            pht_wdata;

  logic                  ras_push;
  logic                  ras_pop;
  logic [31:0]           ras_push_pc;
  logic [31:0]           ras_top;
  logic [RAS_PTR_W-1:0]  ras_ptr;
  logic                  ras_fix;
  logic [RAS_PTR_W-1:0]  ras_fix_ptr;
  logic                  ras_fix_push;
  logic [31:0]           ras_fix_pc;

  core_npc #(
    .BTB_ADDR_W(BTB_ADDR_W),
    .RESET_PC  (RESET_PC)
  ) u_core_npc (
    .clk          (clk),
    .rst_n        (rst_n),
    .stall_i      (stall_i),
    .redirect_i   (redirect_i),
    .redirect_pc_i(redirect_pc_i),
    .btb_entry_i  (btb_rdata),
    .lphr_i       (lphr),
    .history_i    (history),
    .ras_top_i    (ras_top),
    .ras_ptr_i    (ras_ptr),
    .btb_raddr_o  (btb_raddr),
    .dir_pc_o     (dir_pc),
    .ras_push_o   (ras_push),
    .ras_pop_o    (ras_pop),
    .ras_push_pc_o(ras_push_pc),
    .pc_o         (pc_o),
    .valid_o      (valid_o),
    .predict_o    (predict_o)
  );

  // read follows the pc register enable so the entry stays aligned
  btb_table #(
    .BTB_ADDR_W(BTB_ADDR_W)
  ) u_btb_table (
    .clk    (clk),
    .rst_n  (rst_n),
    .re_i   (!stall_i || redirect_i),
    .raddr_i(btb_raddr),
    .we_i   (btb_we),
    .waddr_i(btb_waddr),
    .wdata_i(btb_wdata),
    .rdata_o(btb_rdata)
  );

  dir_predictor #(
    .BHT_ADDR_W(BHT_ADDR_W)
  ) u_dir_predictor (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc_i       (dir_pc),
    .bht_we_i   (bht_we),
    .bht_waddr_i(bht_waddr),
    .bht_wdata_i(bht_wdata),
    .pht_we_i   (pht_we),
    .pht_waddr_i(pht_waddr),
    .pht_wdata_i(pht_wdata),
    .history_o  (history),
    .lphr_o     (lphr)
  );

  ras_stack u_ras_stack (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall_i   (stall_i),
    .push_i    (ras_push),
    .pop_i     (ras_pop),
    .push_pc_i (ras_push_pc),
    .fix_i     (ras_fix),
    .fix_ptr_i (ras_fix_ptr),
    .fix_push_i(ras_fix_push),
    .fix_pc_i  (ras_fix_pc),
    .top_o     (ras_top),
    .ptr_o     (ras_ptr)
  );

  bpu_update #(
    .BTB_ADDR_W(BTB_ADDR_W),
    .BHT_ADDR_W(BHT_ADDR_W)
  ) u_bpu_update (
    .correct_i     (correct_i),
    .btb_we_o      (btb_we),
    .btb_waddr_o   (btb_waddr),
    .btb_wdata_o   (btb_wdata),
    .bht_we_o      (bht_we),
    .bht_waddr_o   (bht_waddr),
    .bht_wdata_o   (bht_wdata),
    .pht_we_o      (pht_we),
    .pht_waddr_o   (pht_waddr),
    .pht_wdata_o   (pht_wdata),
    .ras_fix_o     (ras_fix),
    .ras_fix_ptr_o (ras_fix_ptr),
    .ras_fix_push_o(ras_fix_push),
    .ras_fix_pc_o  (ras_fix_pc)
  );

endmodule

//--- hdl/core_npc.sv
`timescale 1ns/100ps

module core_npc import bpu_pkg::*; #(
  parameter int          BTB_ADDR_W = 6,
  parameter logic [31:0] RESET_PC   = 32'h1c00_0000
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  stall_i,
  input  logic                  redirect_i,
  input  logic [31:0]           redirect_pc_i,
  input  btb_entry_t            btb_entry_i,
  input  logic [1:0]            lphr_i,
  input  logic [HIST_W-1:0]     history_i,
  input  logic [31:0]           ras_top_i,
  input  logic [RAS_PTR_W-1:0]  ras_ptr_i,
  output logic [BTB_ADDR_W-1:0] btb_raddr_o,
  output logic [31:0]           dir_pc_o,
  output logic                  ras_push_o,
  output logic                  ras_pop_o,
  output logic [31:0]           ras_push_pc_o,
  output logic [1:0][31:0]      pc_o,
  output logic [1:0]            valid_o,
  output bpu_predict_t          predict_o
);

  logic [31:0]          pc_q;
  logic [31:0]          ppc;
  logic [31:0]          seq_pc;
  logic [31:0]          jump_pc;
  logic [BTB_TAG_W-1:0] pc_tag;
  logic                 pc_en;
  logic                 hit;
  logic                 taken;

  // redirect still lands while stalled
  assign pc_en = !stall_i || redirect_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q <= RESET_PC;
    end else if (pc_en) begin
      pc_q <= ppc;
    end
  end

  // pair is always 8-byte aligned, pc_q[2] only marks the start slot
  assign pc_o[0] = {pc_q[31:3], 1'b0, pc_q[1:0]};
  assign pc_o[1] = {pc_q[31:3], 1'b1, pc_q[1:0]};

  assign dir_pc_o = pc_q;

  // btb entry read last cycle belongs to pc_q
  assign pc_tag = pc_q[BTB_TAG_W+BTB_ADDR_W+2:BTB_ADDR_W+3];
  assign hit    = btb_entry_i.valid && (btb_entry_i.tag == pc_tag) &&
                  (!pc_q[2] || btb_entry_i.fsc);
  assign taken  = hit && (btb_entry_i.target_type != NPC) &&
                  (!btb_entry_i.dir_type || lphr_i[1]);

  always_comb begin
    seq_pc = {pc_q[31:3], 3'b000} + 32'd8;
    if (btb_entry_i.target_type == RETURN) begin
      jump_pc = ras_top_i;
    end else begin
      jump_pc = {btb_entry_i.target_pc, 2'b00};
    end
    if (redirect_i) begin
      ppc = redirect_pc_i;
    end else if (taken) begin
      ppc = jump_pc;
    end else begin
      ppc = seq_pc;
    end
  end

  assign btb_raddr_o = ppc[BTB_ADDR_W+2:3];

  always_comb begin
    if (stall_i) begin
      valid_o = 2'b00;
    end else if (taken && !btb_entry_i.fsc) begin
      // taken from slot 0 kills slot 1
      valid_o = 2'b01;
    end else if (pc_q[2]) begin
      valid_o = 2'b10;
    end else begin
      valid_o = 2'b11;
    end
  end

  // speculative return stack update, dropped on redirect
  assign ras_push_o    = taken && (btb_entry_i.target_type == CALL) && !redirect_i;
  assign ras_pop_o     = taken && (btb_entry_i.target_type == RETURN) && !redirect_i;
  assign ras_push_pc_o = {pc_q[31:3], btb_entry_i.fsc, 2'b00} + 32'd4;

  always_comb begin
    predict_o.taken       = taken;
    predict_o.predict_pc  = ppc;
    predict_o.lphr        = lphr_i;
    predict_o.history     = history_i;
    predict_o.target_type = hit ? btb_entry_i.target_type : NPC;
    predict_o.dir_type    = hit && btb_entry_i.dir_type;
    predict_o.ras_ptr     = ras_ptr_i;
  end

endmodule

//--- hdl/bpu_update.sv
`timescale 1ns/100ps

module bpu_update import bpu_pkg::*; #(
  parameter  int BTB_ADDR_W = 6,
  parameter  int BHT_ADDR_W = 4,
  localparam int PHT_ADDR_W = HIST_W + 2
) (
  input  bpu_correct_t          correct_i,
  output logic                  btb_we_o,
  output logic [BTB_ADDR_W-1:0] btb_waddr_o,
  output btb_entry_t            btb_wdata_o,
  output logic                  bht_we_o,
  output logic [BHT_ADDR_W-1:0] bht_waddr_o,
  output logic [HIST_W-1:0]     bht_wdata_o,
  output logic                  pht_we_o,
  output logic [PHT_ADDR_W-1:0] pht_waddr_o,
  output logic [1:0]            pht_wdata_o,
  output logic                  ras_fix_o,
  output logic [RAS_PTR_W-1:0]  ras_fix_ptr_o,
  output logic                  ras_fix_push_o,
  output logic [31:0]           ras_fix_pc_o
);

  logic [HIST_W-1:0] new_hist;

  assign new_hist = {correct_i.history[HIST_W-2:0], correct_i.true_taken};

  // every miss rewrites the btb entry
  assign btb_we_o    = correct_i.miss;
  assign btb_waddr_o = correct_i.pc[BTB_ADDR_W+2:3];
  always_comb begin
    btb_wdata_o.valid       = 1'b1;
    btb_wdata_o.fsc         = correct_i.pc[2];
    btb_wdata_o.tag         = correct_i.pc[BTB_TAG_W+BTB_ADDR_W+2:BTB_ADDR_W+3];
    btb_wdata_o.dir_type    = correct_i.true_dir;
    btb_wdata_o.target_type = correct_i.true_target_type;
    btb_wdata_o.target_pc   = correct_i.true_target[31:2];
  end

  // direction tables only train on conditional branches
  assign bht_we_o    = correct_i.miss && correct_i.true_dir;
  assign bht_waddr_o = correct_i.pc[BHT_ADDR_W+2:3] ^
                       correct_i.pc[2*BHT_ADDR_W+2:BHT_ADDR_W+3];
  assign bht_wdata_o = new_hist;

  assign pht_we_o    = correct_i.miss && correct_i.true_dir;
  assign pht_waddr_o = {correct_i.pc[11:10], new_hist};
  assign pht_wdata_o = next_lphr(correct_i.lphr, correct_i.true_taken);

  assign ras_fix_o      = correct_i.miss;
  assign ras_fix_ptr_o  = correct_i.ras_ptr;
  assign ras_fix_push_o = (correct_i.true_target_type == CALL);
  assign ras_fix_pc_o   = correct_i.pc + 32'd4;

endmodule

//--- hdl/ras_stack.sv
`timescale 1ns/100ps

module ras_stack import bpu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 stall_i,
  input  logic                 push_i,
  input  logic                 pop_i,
  input  logic [31:0]          push_pc_i,
  input  logic                 fix_i,
  input  logic [RAS_PTR_W-1:0] fix_ptr_i,
  input  logic                 fix_push_i,
  input  logic [31:0]          fix_pc_i,
  output logic [31:0]          top_o,
  output logic [RAS_PTR_W-1:0] ptr_o
);

  logic [31:0]          stack_q [RAS_DEPTH];
  logic [RAS_PTR_W-1:0] ptr_q;
  logic [RAS_PTR_W-1:0] top_idx;
  logic                 spec_push;
  logic                 spec_pop;

  assign spec_push = !stall_i && push_i;
  assign spec_pop  = !stall_i && pop_i;

  // ptr points at the next free slot, wraps around
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr_q <= '0;
    end else if (spec_push) begin
      ptr_q <= ptr_q + 1'b1;
    end else if (spec_pop) begin
      ptr_q <= ptr_q - 1'b1;
    end else if (fix_i) begin
      ptr_q <= fix_push_i ? fix_ptr_i + 1'b1 : fix_ptr_i;
    end
  end

  always_ff @(posedge clk) begin
    if (spec_push) begin
      stack_q[ptr_q] <= push_pc_i;
    end else if (!spec_pop && fix_i && fix_push_i) begin
      stack_q[fix_ptr_i] <= fix_pc_i;
    end
  end

  assign top_idx = ptr_q - 1'b1;
  assign top_o   = stack_q[top_idx];
  assign ptr_o   = ptr_q;

endmodule

//--- bpu_tables/dir_predictor.sv
`timescale 1ns/100ps

module dir_predictor import bpu_pkg::*; #(
  parameter  int BHT_ADDR_W = 4,
  localparam int PHT_ADDR_W = HIST_W + 2
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [31:0]           pc_i,
  input  logic                  bht_we_i,
  input  logic [BHT_ADDR_W-1:0] bht_waddr_i,
  input  logic [HIST_W-1:0]     bht_wdata_i,
  input  logic                  pht_we_i,
  input  logic [PHT_ADDR_W-1:0] pht_waddr_i,
  input  logic [1:0]            pht_wdata_i,
  output logic [HIST_W-1:0]     history_o,
  output logic [1:0]            lphr_o
);

  localparam int BHT_DEPTH = 1 << BHT_ADDR_W;
  localparam int PHT_DEPTH = 1 << PHT_ADDR_W;

  logic [HIST_W-1:0]     bht_q [BHT_DEPTH];
  logic [1:0]            pht_q [PHT_DEPTH];
  logic [BHT_ADDR_W-1:0] bht_raddr;
  logic [PHT_ADDR_W-1:0] pht_raddr;

  // two pc fields folded together
  assign bht_raddr = pc_i[BHT_ADDR_W+2:3] ^ pc_i[2*BHT_ADDR_W+2:BHT_ADDR_W+3];
  assign history_o = bht_q[bht_raddr];

  assign pht_raddr = {pc_i[11:10], history_o};
  assign lphr_o    = pht_q[pht_raddr];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < BHT_DEPTH; i++) begin
        bht_q[i] <= '0;
      end
    end else if (bht_we_i) begin
      bht_q[bht_waddr_i] <= bht_wdata_i;
    end
  end

  // counters start at strongly not taken
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < PHT_DEPTH; i++) begin
        pht_q[i] <= 2'b00;
      end
    end else if (pht_we_i) begin
      pht_q[pht_waddr_i] <= pht_wdata_i;
    end
  end

endmodule

//--- bpu_tables/btb_table.sv
`timescale 1ns/100ps

module btb_table import bpu_pkg::*; #(
  parameter int BTB_ADDR_W = 6
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  re_i,
  input  logic [BTB_ADDR_W-1:0] raddr_i,
  input  logic                  we_i,
  input  logic [BTB_ADDR_W-1:0] waddr_i,
  input  btb_entry_t            wdata_i,
  output btb_entry_t            rdata_o
);

  localparam int DEPTH = 1 << BTB_ADDR_W;

  btb_entry_t       mem_q [DEPTH];
  logic [DEPTH-1:0] valid_q;
  btb_entry_t       rd_entry_q;
  logic             rd_valid_q;
  logic             bypass;

  // same-cycle write is visible to the read
  assign bypass = we_i && (waddr_i == raddr_i);

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (we_i) begin
      valid_q[waddr_i] <= wdata_i.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid_q <= 1'b0;
    end else if (re_i) begin
      rd_valid_q <= bypass ? wdata_i.valid : valid_q[raddr_i];
    end
  end

  always_ff @(posedge clk) begin
    if (re_i) begin
      rd_entry_q <= bypass ? wdata_i : mem_q[raddr_i];
    end
  end

  always_comb begin
    rdata_o       = rd_entry_q;
    rdata_o.valid = rd_valid_q;
  end

endmodule

//--- common/bpu_pkg.sv
package bpu_pkg;

  // return stack geometry
  localparam int RAS_DEPTH = 8;
  localparam int RAS_PTR_W = 3;

  // btb tag sits just above the index bits
  localparam int BTB_TAG_W = 8;

  // local history length per branch
  localparam int HIST_W = 4;

  typedef enum logic [1:0] {
    NPC    = 2'd0,
    CALL   = 2'd1,
    RETURN = 2'd2,
    IMM    = 2'd3
  } target_type_e;

  typedef struct packed {
    logic                 valid;
    logic                 fsc;
    logic [BTB_TAG_W-1:0] tag;
    logic                 dir_type;
    target_type_e         target_type;
    logic [29:0]          target_pc;
  } btb_entry_t;

  typedef struct packed {
    logic                 taken;
    logic [31:0]          predict_pc;
    logic [1:0]           lphr;
    logic [HIST_W-1:0]    history;
    target_type_e         target_type;
    logic                 dir_type;
    logic [RAS_PTR_W-1:0] ras_ptr;
  } bpu_predict_t;

  typedef struct packed {
    logic                 miss;
    logic [31:0]          pc;
    logic [31:0]          true_target;
    logic                 true_taken;
    logic                 true_dir;
    target_type_e         true_target_type;
    logic [1:0]           lphr;
    logic [HIST_W-1:0]    history;
    logic [RAS_PTR_W-1:0] ras_ptr;
  } bpu_correct_t;

  // four-state counter step
  function automatic logic [1:0] next_lphr(input logic [1:0] cnt, input logic taken);
    case (cnt)
      2'b00:   return {1'b0, taken};
      2'b01:   return {taken, 1'b0};
      2'b10:   return {taken, 1'b1};
      default: return {1'b1, taken};
    endcase
  endfunction

endpackage
